/* hdl/bus_pkg.sv */
/*
 * Wishbone classic types for an 8-bit data path.
 * No address, select or error fields: the ports in this subsystem
 * carry single-byte writes only and never decode an address.
 */

package bus_pkg;

	// data bus width, one byte per transfer
	localparam int unsigned WB_DW = 8;

	// master to slave
	// cyc frames the whole transfer, stb marks a valid beat
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_DW-1:0] dat;
	} wb_req_t;

	// slave to master
	// ack is high for one cycle per accepted beat
	typedef struct packed {
		logic             ack;
		logic [WB_DW-1:0] dat;
	} wb_rsp_t;

endpackage

/* hdl/msg_pkg.sv */
/*
 * Message format shared by the framing, checksum and digit stages.
 * Frames open with '$' and close with '*'. The checksum is the sum of
 * the payload bytes modulo 256, sent as three decimal ASCII digits.
 */

package msg_pkg;

	// frame markers
	localparam logic [7:0] START_CHAR = 8'h24;
	localparam logic [7:0] END_CHAR   = 8'h2A;

	// ascii '0', digits are sent as value plus this offset
	localparam logic [7:0] ASCII_ZERO = 8'h30;

	// "000" to "255"
	localparam int unsigned NUM_DIGITS = 3;

	// one accepted byte, already classified
	// is_start and is_end are exclusive, payload has both low
	typedef struct packed {
		logic       valid;
		logic       is_start;
		logic       is_end;
		logic [7:0] data;
	} msg_byte_t;

	// finished checksum, valid pulses for one cycle
	typedef struct packed {
		logic       valid;
		logic [7:0] sum;
	} csum_t;

endpackage

/* hdl/frame_delimiter.sv */
/*
 * Wishbone classic slave for the incoming byte stream.
 * Ack is registered and comes one cycle after stb. Read cycles are
 * acked but return zero. Acks stop while busy_i is high and in the
 * two cycles after an end byte, until the digit sender reports busy.
 */

`timescale 1ns/1ps

module frame_delimiter (
	input  logic               clk,
	input  logic               rst,
	input  bus_pkg::wb_req_t   wb_req_i,
	output bus_pkg::wb_rsp_t   wb_rsp_o,
	input  logic               busy_i,
	output msg_pkg::msg_byte_t byte_o
);

	import msg_pkg::*;

	logic       ack_q;
	logic       in_frame_q;
	logic       end_hold_q;
	logic       valid_q;
	logic       start_q;
	logic       end_q;
	logic [7:0] data_q;

	logic take;
	logic wr;
	logic is_start;
	logic is_end;

	always_comb begin
		// !ack_q keeps the held beat from being acked twice
		take = wb_req_i.cyc && wb_req_i.stb && !ack_q && !busy_i && !end_hold_q;
		wr = take && wb_req_i.we;
		// '$' counts anywhere, it restarts an open frame too
		is_start = (wb_req_i.dat == START_CHAR);
		// a '*' outside a frame is just dropped
		is_end = in_frame_q && (wb_req_i.dat == END_CHAR);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			in_frame_q <= 1'b0;
			end_hold_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			ack_q <= take;
			// forward markers and in-frame payload only
			valid_q <= wr && (is_start || in_frame_q);
			if (wr && is_start) begin
				in_frame_q <= 1'b1;
			end else if (wr && is_end) begin
				in_frame_q <= 1'b0;
			end
			// covers the gap until the sender raises busy
			if (wr && is_end) begin
				end_hold_q <= 1'b1;
			end else if (busy_i) begin
				end_hold_q <= 1'b0;
			end
		end
	end

	// byte fields, qualified by valid_q
	always_ff @(posedge clk) begin
		if (take) begin
			start_q <= is_start;
			end_q <= is_end;
			data_q <= wb_req_i.dat;
		end
	end

	assign wb_rsp_o = '{ack: ack_q, dat: '0};
	assign byte_o = '{valid: valid_q, is_start: start_q, is_end: end_q, data: data_q};

	// the master still holds its beat in the ack cycle
	a_ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
		wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
		else $error("ack raised without a cycle in progress");

endmodule

/* hdl/checksum_accum.sv */
/*
 * Modulo-256 sum of the payload bytes in a frame.
 * Expects classified bytes from the framing stage, with no payload
 * before the first start byte. The result pulses one cycle after the
 * end byte. There is no back-pressure on either side.
 */

`timescale 1ns/1ps

module checksum_accum (
	input  logic               clk,
	input  logic               rst,
	input  msg_pkg::msg_byte_t byte_i,
	output msg_pkg::csum_t     csum_o
);

	logic       valid_q;
	logic [7:0] sum_q;
	logic [7:0] result_q;

	// valid is a single-cycle strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= byte_i.valid && byte_i.is_end;
		end
	end

	// running sum and result
	always_ff @(posedge clk) begin
		if (byte_i.valid) begin
			if (byte_i.is_start) begin
				// new frame, or '$' inside a frame
				sum_q <= '0;
			end else if (byte_i.is_end) begin
				// the '*' itself is not added
				result_q <= sum_q;
			end else begin
				// 8-bit add, wraps mod 256
				sum_q <= sum_q + byte_i.data;
			end
		end
	end

	assign csum_o = '{valid: valid_q, sum: result_q};

	// the framing stage must never mark one byte as both
	a_marker_exclusive: assert property (@(posedge clk) disable iff (rst)
		byte_i.valid |-> !(byte_i.is_start && byte_i.is_end))
		else $error("byte marked as both start and end");

endmodule

/* hdl/ascii_digit_tx.sv */
/*
 * Sends a checksum as three ASCII decimal digits, hundreds first.
 * Conversion uses repeated subtraction, so its length depends on the
 * value. Each digit is one classic write with cyc low for a cycle in
 * between. A new sum must not arrive while busy_o is high.
 */

`timescale 1ns/1ps

module ascii_digit_tx (
	input  logic             clk,
	input  logic             rst,
	input  msg_pkg::csum_t   csum_i,
	output bus_pkg::wb_req_t wb_req_o,
	input  bus_pkg::wb_rsp_t wb_rsp_i,
	output logic             busy_o
);

	import msg_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_DIV,
		S_WRITE,
		S_GAP
	} state_t;

	state_t     state_q;
	logic [1:0] idx_q;
	logic [7:0] rem_q;
	logic [1:0] hund_q;
	logic [3:0] tens_q;
	logic [3:0] digit;
	logic       in_write;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_IDLE;
			idx_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (csum_i.valid) begin
						state_q <= S_DIV;
					end
				end
				S_DIV: begin
					// remainder below 10 is the units digit
					if (rem_q < 8'd10) begin
						state_q <= S_WRITE;
						idx_q <= '0;
					end
				end
				S_WRITE: begin
					if (wb_rsp_i.ack) begin
						if (idx_q == 2'(NUM_DIGITS - 1)) begin
							state_q <= S_IDLE;
						end else begin
							idx_q <= idx_q + 2'd1;
							state_q <= S_GAP;
						end
					end
				end
				// one idle cycle with cyc low
				S_GAP: state_q <= S_WRITE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// divide by subtraction, hundreds before tens
	always_ff @(posedge clk) begin
		if (state_q == S_IDLE && csum_i.valid) begin
			rem_q <= csum_i.sum;
			hund_q <= '0;
			tens_q <= '0;
		end else if (state_q == S_DIV) begin
			if (rem_q >= 8'd100) begin
				rem_q <= rem_q - 8'd100;
				hund_q <= hund_q + 2'd1;
			end else if (rem_q >= 8'd10) begin
				rem_q <= rem_q - 8'd10;
				tens_q <= tens_q + 4'd1;
			end
		end
	end

	always_comb begin
		case (idx_q)
			2'd0: digit = {2'b00, hund_q};
			2'd1: digit = tens_q;
			default: digit = rem_q[3:0];
		endcase
	end

	// digit registers hold still in S_WRITE, so dat is stable
	assign in_write = (state_q == S_WRITE);
	assign wb_req_o = '{cyc: in_write, stb: in_write, we: 1'b1,
		dat: ASCII_ZERO + {4'b0000, digit}};
	assign busy_o = (state_q != S_IDLE);

	// every acked digit ends its cycle, so cyc drops between digits
	a_cyc_gap: assert property (@(posedge clk) disable iff (rst)
		(wb_req_o.stb && wb_rsp_i.ack) |=> !wb_req_o.cyc)
		else $error("cyc held after digit ack");

	a_dat_stable: assert property (@(posedge clk) disable iff (rst)
		(wb_req_o.stb && !wb_rsp_i.ack) |=> (wb_req_o.stb && $stable(wb_req_o.dat)))
		else $error("digit changed before ack");

	// the framing stage holds off input until busy drops
	a_no_sum_busy: assert property (@(posedge clk) disable iff (rst)
		csum_i.valid |-> !busy_o)
		else $error("checksum arrived while digits pending");

endmodule

/* hdl/checksum_top.sv */
/*
 * Frame checksum subsystem, byte stream in, ASCII digits out.
 * Both ports are Wishbone classic with 8-bit data and no addressing.
 * A stalled output sink also stalls the input port.
 */

`timescale 1ns/1ps

module checksum_top (
	input  logic             clk,
	input  logic             rst,
	input  bus_pkg::wb_req_t in_req_i,
	output bus_pkg::wb_rsp_t in_rsp_o,
	output bus_pkg::wb_req_t out_req_o,
	input  bus_pkg::wb_rsp_t out_rsp_i
);

	import msg_pkg::*;

	msg_byte_t byte_w;
	csum_t     csum_w;
	// back-pressure from the digit sender to the input port
	logic      busy_w;

	frame_delimiter u_delim (
		.clk      (clk),
		.rst      (rst),
		.wb_req_i (in_req_i),
		.wb_rsp_o (in_rsp_o),
		.busy_i   (busy_w),
		.byte_o   (byte_w)
	);

	checksum_accum u_accum (
		.clk    (clk),
		.rst    (rst),
		.byte_i (byte_w),
		.csum_o (csum_w)
	);

	ascii_digit_tx u_tx (
		.clk      (clk),
		.rst      (rst),
		.csum_i   (csum_w),
		.wb_req_o (out_req_o),
		.wb_rsp_i (out_rsp_i),
		.busy_o   (busy_w)
	);

endmodule

/* verif/tb_checksum.sv */
/*
 * Testbench for the frame checksum subsystem.
 * Expected digits come from a framing model applied to the sent bytes.
 * The output sink stalls each digit by 0 to 3 cycles from a fixed table.
 * Checking is done by the concurrent assertions below.
 */

`timescale 1ns/1ps

module tb_checksum;

	import bus_pkg::*;
	import msg_pkg::*;

	localparam int CLK_HALF     = 4;
	localparam int BYTE_CYCLES  = 5;
	localparam int FRAME_CYCLES = 40;
	localparam int SETUP_CYCLES = 20;

	logic       clk;
	logic       rst;
	wb_req_t    in_req;
	wb_rsp_t    in_rsp;
	wb_req_t    out_req;
	wb_rsp_t    out_rsp = '0;
	// stream to send, segment ends mark where a frame is done
	logic [7:0] stim_mem [0:255];
	int         seg_end [0:15];
	int         stim_len = 0;
	int         seg_cnt = 0;
	// expected ascii digits in arrival order
	logic [7:0] exp_mem [0:63];
	int         exp_cnt = 0;
	int         rd_idx = 0;
	logic [7:0] exp_head;
	logic       exp_avail;
	logic       digit_ack;
	logic       ref_in_frame = 1'b0;
	logic [7:0] ref_sum = '0;
	integer     seed;
	logic [1:0] stall_tab [0:63];
	logic [5:0] stall_pick = '0;
	logic [1:0] stall_cnt = '0;
	logic       stalling = 1'b0;
	logic       idle_phase = 1'b0;
	int         cycle_cnt = 0;
	int         cycle_limit = 1000000;
	int         mismatch_errs = 0;
	int         protocol_errs = 0;

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	checksum_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.in_req_i  (in_req),
		.in_rsp_o  (in_rsp),
		.out_req_o (out_req),
		.out_rsp_i (out_rsp)
	);

	assign digit_ack = out_req.cyc && out_req.stb && out_rsp.ack;
	assign exp_avail = (rd_idx < exp_cnt);
	assign exp_head = exp_mem[6'(rd_idx)];

	// next expected digit moves on with every acked write
	always @(posedge clk) begin
		if (rst) begin
			rd_idx <= 0;
		end else if (digit_ack && exp_avail) begin
			rd_idx <= rd_idx + 1;
		end
	end

	// sink, ack registered after a table-driven stall
	always @(posedge clk) begin
		if (rst) begin
			out_rsp <= '0;
			stalling <= 1'b0;
		end else if (out_req.cyc && out_req.stb && !out_rsp.ack) begin
			if (!stalling) begin
				if (stall_tab[stall_pick] == 2'd0) begin
					out_rsp.ack <= 1'b1;
				end else begin
					stalling <= 1'b1;
					stall_cnt <= stall_tab[stall_pick] - 2'd1;
				end
				stall_pick <= stall_pick + 6'd1;
			end else if (stall_cnt == 2'd0) begin
				out_rsp.ack <= 1'b1;
				stalling <= 1'b0;
			end else begin
				stall_cnt <= stall_cnt - 2'd1;
			end
		end else begin
			out_rsp.ack <= 1'b0;
		end
	end

	a_digit_expected: assert property (@(posedge clk) disable iff (rst)
		digit_ack |-> exp_avail)
		else begin
			protocol_errs++;
			$display("digit written at %0t with no closed frame pending", $time);
		end

	a_digit_value: assert property (@(posedge clk) disable iff (rst)
		(digit_ack && exp_avail) |-> (out_req.dat == exp_head))
		else begin
			mismatch_errs++;
			$display("mismatch at %0t: digit %0d expected '%c', got '%c'", $time,
				$sampled(rd_idx), $sampled(exp_head), $sampled(out_req.dat));
		end

	// digits only ever leave as writes
	a_digit_write: assert property (@(posedge clk) disable iff (rst)
		out_req.stb |-> out_req.we)
		else begin
			protocol_errs++;
			$display("digit transfer at %0t is not a write", $time);
		end

	// end byte acked, digits pending, so input must hold
	a_input_held: assert property (@(posedge clk) disable iff (rst)
		in_rsp.ack |-> !exp_avail)
		else begin
			protocol_errs++;
			$display("input byte acked at %0t while digits still pending", $time);
		end

	a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		idle_phase |-> (!out_req.cyc && !out_req.stb && !in_rsp.ack))
		else begin
			protocol_errs++;
			$display("bus activity at %0t during an idle gap", $time);
		end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, DUT stopped making progress", cycle_cnt);
			$display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
			$display("Test failed");
			$finish;
		end
	end

	function automatic void add_byte(input logic [7:0] b);
		stim_mem[8'(stim_len)] = b;
		stim_len++;
	endfunction

	function automatic void add_text(input string s);
		for (int i = 0; i < s.len(); i++) begin
			add_byte(8'(s[i]));
		end
	endfunction

	function automatic void close_segment();
		seg_end[4'(seg_cnt)] = stim_len;
		seg_cnt++;
	endfunction

	// payload avoids both markers
	function automatic void add_random_frame(input int len);
		logic [7:0] b;
		add_byte(START_CHAR);
		for (int i = 0; i < len; i++) begin
			b = 8'($random(seed));
			if (b == START_CHAR || b == END_CHAR) begin
				b = b ^ 8'h01;
			end
			add_byte(b);
		end
		add_byte(END_CHAR);
		close_segment();
	endfunction

	// decimal split by division, hundreds first
	function automatic void push_digits(input logic [7:0] sum);
		int value;
		value = int'(sum);
		exp_mem[6'(exp_cnt)] = ASCII_ZERO + 8'(value / 100);
		exp_mem[6'(exp_cnt + 1)] = ASCII_ZERO + 8'((value / 10) % 10);
		exp_mem[6'(exp_cnt + 2)] = ASCII_ZERO + 8'(value % 10);
		exp_cnt = exp_cnt + 3;
	endfunction

	// framing rules applied to each acked byte
	function automatic void model_byte(input logic [7:0] b);
		if (b == START_CHAR) begin
			ref_in_frame = 1'b1;
			ref_sum = '0;
		end else if (ref_in_frame && b == END_CHAR) begin
			ref_in_frame = 1'b0;
			push_digits(ref_sum);
		end else if (ref_in_frame) begin
			ref_sum = ref_sum + b;
		end
	endfunction

	task automatic write_byte(input logic [7:0] b);
		@(posedge clk);
		in_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, dat: b};
		@(negedge clk);
		while (!in_rsp.ack) begin
			@(negedge clk);
		end
		@(posedge clk);
		in_req <= '0;
		model_byte(b);
	endtask

	task automatic wait_digits_done();
		@(negedge clk);
		while (rd_idx != exp_cnt) begin
			@(negedge clk);
		end
	endtask

	task automatic idle_gap(input int cycles);
		@(posedge clk);
		idle_phase <= 1'b1;
		repeat (cycles) @(posedge clk);
		idle_phase <= 1'b0;
	endtask

	initial begin
		int pos;
		in_req = '0;
		rst = 1'b1;
		seed = 32'hec40_54ce;
		for (int i = 0; i < 64; i++) begin
			stall_tab[6'(i)] = 2'($random(seed));
		end
		// sum 7, leading zeros
		add_byte(START_CHAR);
		add_byte(8'h03);
		add_byte(8'h04);
		add_byte(END_CHAR);
		close_segment();
		// 405 wraps to 149
		add_text("$ABCDEF*");
		close_segment();
		// 255, then 256 wrapping to 0
		add_byte(START_CHAR);
		add_byte(8'h80);
		add_byte(8'h7f);
		add_byte(END_CHAR);
		close_segment();
		add_byte(START_CHAR);
		add_byte(8'h80);
		add_byte(8'h80);
		add_byte(END_CHAR);
		close_segment();
		// noise around the frame, restart inside it, sum of "12" only
		add_text("*ab$xy$12*q*z");
		close_segment();
		add_text("$*");
		close_segment();
		add_random_frame(3);
		add_random_frame(8);
		add_random_frame(1);
		add_random_frame(6);
		cycle_limit = stim_len * BYTE_CYCLES + seg_cnt * FRAME_CYCLES + SETUP_CYCLES;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		idle_gap(4);
		pos = 0;
		for (int s = 0; s < seg_cnt; s++) begin
			while (pos < seg_end[4'(s)]) begin
				write_byte(stim_mem[8'(pos)]);
				pos++;
			end
			wait_digits_done();
			idle_gap(3);
		end
		$display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
		if (mismatch_errs == 0 && protocol_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sim.f */
hdl/bus_pkg.sv
hdl/msg_pkg.sv
hdl/frame_delimiter.sv
hdl/checksum_accum.sv
hdl/ascii_digit_tx.sv
hdl/checksum_top.sv
verif/tb_checksum.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_checksum
FILELIST  = sim.f
OBJDIR    = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
